// ==== vlog.f ====
hdl/bg_render_pkg.sv
hdl/bg_fetch_sequencer.sv
hdl/bg_addr_gen.sv
hdl/bg_fetch_latch.sv
hdl/bg_shifters.sv
hdl/bg_render_top.sv
tests/tb_clock_gen.sv
tests/bg_render_assert.sv
tests/bg_render_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the background render testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bg_render_tb \
    -f vlog.f -o bg_render_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/bg_render_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// ==== tests/bg_render_tb.sv ====
`timescale 1ns/1ps

module bg_render_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_WAIT   = 4;                       // Reset cycles plus one
    localparam int DOTS         = 341;
    localparam int FRAME_LINES  = 6;                       // Shortened frame
    localparam int NUM_LINES    = 2 * FRAME_LINES;
    localparam int WATCHDOG_NS  = (NUM_LINES * DOTS + 20) * CLK_PERIOD;
    localparam int MEM_WORDS    = 16384;

    logic                      clk;
    logic                      rst;
    logic                      rst_seen;
    bg_render_pkg::beam_t      beam;
    bg_render_pkg::scroll_t    scroll;
    logic                      render_en;
    logic                      rendering_line;
    logic                      bg_en;
    logic [3:0]                clip_start;
    logic [7:0]                nt_data;
    logic [7:0]                pat_data;
    bg_render_pkg::mem_port_t  nt_port;
    bg_render_pkg::mem_port_t  pat_port;
    bg_render_pkg::pixel_t     pixel;

    logic [7:0] nt_mem  [MEM_WORDS];
    logic [7:0] pat_mem [MEM_WORDS];

    // Reference model state with valid flags for the unreset registers
    logic [3:0]        m_step;
    logic [13:0]       m_nt_addr;
    logic [13:0]       m_pat_addr;
    logic              m_nt_addr_v;
    logic              m_pat_addr_v;
    logic [7:0]        m_index;
    logic              m_index_v;
    logic [7:0]        m_lo;
    logic [7:0]        m_hi;
    logic [1:0]        m_attr;
    logic              m_lo_v;
    logic              m_hi_v;
    logic              m_attr_v;
    logic [3:0][15:0]  m_sh;
    logic [3:0][15:0]  m_sh_v;

    int port_errors;
    int pixel_errors;
    int unsigned seed_ret;

    tb_clock_gen u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    bg_render_top dut (
        .clk_i            (clk),
        .rst_i            (rst),
        .beam_i           (beam),
        .scroll_i         (scroll),
        .render_en_i      (render_en),
        .rendering_line_i (rendering_line),
        .bg_en_i          (bg_en),
        .clip_start_i     (clip_start),
        .nt_data_i        (nt_data),
        .pat_data_i       (pat_data),
        .nt_port_o        (nt_port),
        .pat_port_o       (pat_port),
        .pixel_o          (pixel)
    );

    assign nt_data  = nt_mem[nt_port.addr];                // Memory answers in the same cycle
    assign pat_data = pat_mem[pat_port.addr];

    always @(posedge clk) begin
        rst_seen <= rst;
    end

    function automatic logic [8:0] line_of(int idx);
        case (idx)
            0:       return 9'd0;
            1:       return 9'd1;
            2:       return 9'd2;
            3:       return 9'd239;                        // Last visible line
            4:       return 9'd240;                        // Idle line
            default: return 9'd261;                        // Pre-render line
        endcase
    endfunction

    // Odd steps place the address and even steps read
    function automatic logic [3:0] next_step(logic [3:0] step);
        logic [3:0] nxt;
        if (step == 4'd0) begin
            nxt = (rendering_line && (beam.dot == 9'd0 || beam.dot == 9'd320)) ? 4'd1 : 4'd0;
        end else if (step == 4'd8) begin
            nxt = (beam.dot == 9'd256 || beam.dot == 9'd336) ? 4'd0 : 4'd1;
        end else begin
            nxt = step + 4'd1;
        end
        return nxt;
    endfunction

    function automatic bg_render_pkg::shift_ctrl_t ctrl_for_beam();
        bg_render_pkg::shift_ctrl_t ctrl;
        logic in_window;
        in_window = (beam.dot >= 9'd1 && beam.dot <= 9'd256) ||
                    (beam.dot >= 9'd321 && beam.dot <= 9'd336);
        ctrl.shift   = render_en && rendering_line && in_window;
        ctrl.reload  = ctrl.shift && (beam.dot[2:0] == 3'd0) && (beam.dot != 9'd0);
        ctrl.visible = (beam.line < 9'd240) && (beam.dot > {5'd0, clip_start}) &&
                       (beam.dot < 9'd257) && bg_en;
        return ctrl;
    endfunction

    // Applies the clock edge that just passed before the inputs move
    task automatic advance_model();
        logic [3:0]                 nxt;
        bg_render_pkg::shift_ctrl_t ctrl;
        logic [7:0]                 nt_byte;
        logic [7:0]                 pat_byte;
        logic [3:0][7:0]            fill;
        logic [3:0]                 fill_v;
        nxt      = next_step(m_step);
        ctrl     = ctrl_for_beam();
        nt_byte  = nt_mem[m_nt_addr];
        pat_byte = pat_mem[m_pat_addr];
        fill     = {{8{m_attr[1]}}, {8{m_attr[0]}}, m_hi, m_lo};
        fill_v   = {m_attr_v, m_attr_v, m_hi_v, m_lo_v};
        for (int i = 0; i < 4; i++) begin
            if (ctrl.reload) begin
                m_sh[i]   = ((m_sh[i] << 1) & 16'hFF00) | {8'h00, fill[i]};
                m_sh_v[i] = ((m_sh_v[i] << 1) & 16'hFF00) | {8'h00, {8{fill_v[i]}}};
            end else if (ctrl.shift) begin
                m_sh[i]   = m_sh[i] << 1;
                m_sh_v[i] = (m_sh_v[i] << 1) | 16'h0001;   // Zero fill is known
            end
        end
        case (nxt)
            4'd2: begin
                m_index   = nt_byte;
                m_index_v = m_nt_addr_v;
            end
            4'd4: begin
                case ({scroll.coarse_y[1], scroll.coarse_x[1]})
                    2'd0:    m_attr = nt_byte[1:0];
                    2'd1:    m_attr = nt_byte[3:2];
                    2'd2:    m_attr = nt_byte[5:4];
                    default: m_attr = nt_byte[7:6];
                endcase
                m_attr_v = m_nt_addr_v;
            end
            4'd6: begin
                m_lo   = pat_byte;
                m_lo_v = m_pat_addr_v;
            end
            4'd8: begin
                m_hi   = pat_byte;
                m_hi_v = m_pat_addr_v;
            end
            default: ;
        endcase
        case (nxt)
            4'd1: begin
                m_nt_addr   = {2'b10, scroll.nt_v, scroll.nt_h, scroll.coarse_y,
                               scroll.coarse_x};
                m_nt_addr_v = 1'b1;
            end
            4'd3: begin
                m_nt_addr   = {2'b10, scroll.nt_v, scroll.nt_h, 4'b1111,
                               scroll.coarse_y[4:2], scroll.coarse_x[4:2]};
                m_nt_addr_v = 1'b1;
            end
            4'd5, 4'd7: begin
                m_pat_addr   = {1'b0, scroll.pattern_bank, m_index, (nxt == 4'd7),
                                scroll.fine_y};
                m_pat_addr_v = m_index_v;
            end
            default: ;
        endcase
        m_step = rst_seen ? 4'd0 : nxt;
    endtask

    task automatic check_port(input string name, input bg_render_pkg::mem_port_t got,
                              input bg_render_pkg::mem_port_t exp);
        if ((got.rd !== exp.rd) || (exp.rd && (got.addr !== exp.addr))) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            port_errors++;
        end
    endtask

    task automatic check_pixel(input bg_render_pkg::pixel_t got,
                               input bg_render_pkg::pixel_t exp, input logic known);
        if (known && (got !== exp)) begin
            $display("mismatch at %0t ns: pixel_o got %h expected %h", $time, got, exp);
            pixel_errors++;
        end
    endtask

    task automatic check_outputs();
        logic [3:0]                 nxt;
        bg_render_pkg::shift_ctrl_t ctrl;
        bg_render_pkg::mem_port_t   exp_nt;
        bg_render_pkg::mem_port_t   exp_pat;
        bg_render_pkg::pixel_t      exp_pix;
        logic [3:0]                 tap;
        logic                       known;
        nxt          = next_step(m_step);
        ctrl         = ctrl_for_beam();
        exp_nt.addr  = m_nt_addr;
        exp_nt.rd    = render_en && (nxt == 4'd2 || nxt == 4'd4);
        exp_pat.addr = m_pat_addr;
        exp_pat.rd   = render_en && (nxt == 4'd6 || nxt == 4'd8);
        tap          = 4'd15 - {1'b0, scroll.fine_x};
        if (ctrl.visible) begin
            exp_pix = {m_sh[3][tap], m_sh[2][tap], m_sh[1][tap], m_sh[0][tap]};
            known   = m_sh_v[3][tap] && m_sh_v[2][tap] && m_sh_v[1][tap] && m_sh_v[0][tap];
        end else begin
            exp_pix = 4'h0;
            known   = 1'b1;
        end
        check_port("nt_port_o", nt_port, exp_nt);
        check_port("pat_port_o", pat_port, exp_pat);
        check_pixel(pixel, exp_pix, known);
    endtask

    task automatic drive_dot(input logic [8:0] line, input int dot);
        beam.dot  = 9'(dot);
        beam.line = line;
        if (dot == 0) begin                                // New settings per line
            scroll         = 19'($urandom);
            bg_en          = ($urandom % 4) != 0;
            clip_start     = 4'($urandom);
            render_en      = (($urandom % 8) != 0) && (line != 9'd2); // Line 2 never renders
            rendering_line = (line < 9'd240) || (line == 9'd261);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        beam.dot       = 9'd340;
        beam.line      = 9'd261;
        scroll         = '0;
        render_en      = 1'b0;
        rendering_line = 1'b0;
        bg_en          = 1'b0;
        clip_start     = 4'd0;
        port_errors    = 0;
        pixel_errors   = 0;
        m_step         = 4'd0;
        m_nt_addr      = '0;
        m_pat_addr     = '0;
        m_nt_addr_v    = 1'b0;
        m_pat_addr_v   = 1'b0;
        m_index        = '0;
        m_index_v      = 1'b0;
        m_lo           = '0;
        m_hi           = '0;
        m_attr         = '0;
        m_lo_v         = 1'b0;
        m_hi_v         = 1'b0;
        m_attr_v       = 1'b0;
        m_sh           = '0;
        m_sh_v         = '0;
        seed_ret = $urandom(32'hdd2fe9ed);
        for (int a = 0; a < MEM_WORDS; a++) begin
            nt_mem[a]  = 8'($urandom);
            pat_mem[a] = 8'($urandom);
        end
        repeat (RESET_WAIT) begin
            @(negedge clk);
            advance_model();
            check_outputs();
        end
        for (int ln = 0; ln < NUM_LINES; ln++) begin
            for (int d = 0; d < DOTS; d++) begin
                drive_dot(line_of(ln % FRAME_LINES), d);
                @(negedge clk);
                advance_model();
                check_outputs();
            end
        end
        $display("Errors: port %0d, pixel %0d", port_errors, pixel_errors);
        if ((port_errors + pixel_errors) == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/bg_render_assert.sv ====
`timescale 1ns/1ps

module bg_render_assert (
    input logic                     clk_i,
    input logic                     rst_i,
    input logic                     bg_en_i,
    input bg_render_pkg::mem_port_t nt_port_i,
    input bg_render_pkg::mem_port_t pat_port_i,
    input bg_render_pkg::pixel_t    pixel_i
);

    // Only one memory is read per cycle
    rd_exclusive: assert property (@(posedge clk_i) !(nt_port_i.rd && pat_port_i.rd))
        else $error("nt and pattern read strobes high in the same cycle");

    rd_low_after_reset: assert property (@(posedge clk_i)
        rst_i |=> (!nt_port_i.rd && !pat_port_i.rd))
        else $error("read strobe high in the cycle after reset");

    pixel_off_when_disabled: assert property (@(posedge clk_i)
        !bg_en_i |-> (pixel_i == 4'h0))
        else $error("pixel not zero with background disabled");

endmodule

bind bg_render_top bg_render_assert u_assert (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bg_en_i    (bg_en_i),
    .nt_port_i  (nt_port_o),
    .pat_port_i (pat_port_o),
    .pixel_i    (pixel_o)
);

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD  = 20;                      // 40 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o <= 1'b0;                                     // Released on a falling edge
    end

endmodule

// ==== hdl/bg_render_top.sv ====
`timescale 1ns/1ps

module bg_render_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  bg_render_pkg::beam_t        beam_i,
    input  bg_render_pkg::scroll_t      scroll_i,
    input  logic                        render_en_i,
    input  logic                        rendering_line_i,
    input  logic                        bg_en_i,
    input  logic [3:0]                  clip_start_i,
    input  logic [7:0]                  nt_data_i,
    input  logic [7:0]                  pat_data_i,
    output bg_render_pkg::mem_port_t    nt_port_o,
    output bg_render_pkg::mem_port_t    pat_port_o,
    output bg_render_pkg::pixel_t       pixel_o
);

    bg_render_pkg::fetch_step_e step_next;
    bg_render_pkg::shift_ctrl_t shift_ctrl;
    bg_render_pkg::tile_data_t  tile;
    logic [7:0]                 tile_index;                // Feeds the pattern address

    bg_fetch_sequencer u_sequencer (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .beam_i           (beam_i),
        .render_en_i      (render_en_i),
        .rendering_line_i (rendering_line_i),
        .bg_en_i          (bg_en_i),
        .clip_start_i     (clip_start_i),
        .step_next_o      (step_next),
        .shift_ctrl_o     (shift_ctrl)
    );

    bg_addr_gen u_addr_gen (
        .clk_i        (clk_i),
        .step_next_i  (step_next),
        .render_en_i  (render_en_i),
        .scroll_i     (scroll_i),
        .tile_index_i (tile_index),
        .nt_port_o    (nt_port_o),
        .pat_port_o   (pat_port_o)
    );

    bg_fetch_latch u_fetch_latch (
        .clk_i        (clk_i),
        .step_next_i  (step_next),
        .scroll_i     (scroll_i),
        .nt_data_i    (nt_data_i),
        .pat_data_i   (pat_data_i),
        .tile_index_o (tile_index),
        .tile_o       (tile)
    );

    bg_shifters u_shifters (
        .clk_i        (clk_i),
        .shift_ctrl_i (shift_ctrl),
        .tile_i       (tile),
        .fine_x_i     (scroll_i.fine_x),                   // Live fine scroll
        .pixel_o      (pixel_o)
    );

endmodule

// ==== hdl/bg_shifters.sv ====
`timescale 1ns/1ps

module bg_shifters (
    input  logic                        clk_i,
    input  bg_render_pkg::shift_ctrl_t  shift_ctrl_i,
    input  bg_render_pkg::tile_data_t   tile_i,
    input  logic [2:0]                  fine_x_i,
    output bg_render_pkg::pixel_t       pixel_o
);

    localparam int NUM_SHIFTERS = 4;

    // 0 pattern low, 1 pattern high, 2 palette low, 3 palette high
    logic [NUM_SHIFTERS-1:0][bg_render_pkg::SHIFT_W-1:0] shift_r;
    logic [NUM_SHIFTERS-1:0][7:0]                        fill;
    logic [NUM_SHIFTERS-1:0]                             tap;
    logic [3:0]                                          tap_sel;

    assign fill = {{8{tile_i.attr[1]}},
                   {8{tile_i.attr[0]}},                    // Same palette for all 8 dots
                   tile_i.pattern_hi,
                   tile_i.pattern_lo};

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_SHIFTERS; i++) begin
            if (shift_ctrl_i.reload) begin
                shift_r[i] <= {shift_r[i][bg_render_pkg::SHIFT_W-2:7], fill[i]};
            end else if (shift_ctrl_i.shift) begin
                shift_r[i] <= {shift_r[i][bg_render_pkg::SHIFT_W-2:0], 1'b0};
            end
        end
    end

    // Fine scroll picks a bit further down the current tile
    assign tap_sel = 4'hF - {1'b0, fine_x_i};

    always_comb begin
        for (int i = 0; i < NUM_SHIFTERS; i++) begin
            tap[i] = shift_r[i][tap_sel];
        end
    end

    always_comb begin
        if (shift_ctrl_i.visible) begin
            pixel_o.palette = {tap[3], tap[2]};
            pixel_o.pattern = {tap[1], tap[0]};
        end else begin
            pixel_o = '0;                                  // Backdrop outside the window
        end
    end

endmodule

// ==== hdl/bg_fetch_latch.sv ====
`timescale 1ns/1ps

module bg_fetch_latch (
    input  logic                        clk_i,
    input  bg_render_pkg::fetch_step_e  step_next_i,
    input  bg_render_pkg::scroll_t      scroll_i,
    input  logic [7:0]                  nt_data_i,
    input  logic [7:0]                  pat_data_i,
    output logic [7:0]                  tile_index_o,
    output bg_render_pkg::tile_data_t   tile_o
);

    logic [1:0] quadrant;                                  // Which 16x16 area in the attr byte
    logic [1:0] attr_bits;

    assign quadrant = {scroll_i.coarse_y[1], scroll_i.coarse_x[1]};

    always_comb begin
        case (quadrant)
            2'd0:    attr_bits = nt_data_i[1:0];           // Top left
            2'd1:    attr_bits = nt_data_i[3:2];           // Top right
            2'd2:    attr_bits = nt_data_i[5:4];
            default: attr_bits = nt_data_i[7:6];
        endcase
    end

    // Data is taken at the edge that closes the strobe cycle
    always_ff @(posedge clk_i) begin
        case (step_next_i)
            bg_render_pkg::INDEX_GET: begin
                tile_index_o <= nt_data_i;
            end
            bg_render_pkg::ATTR_GET: begin
                tile_o.attr <= attr_bits;
            end
            bg_render_pkg::PAT_LO_GET: begin
                tile_o.pattern_lo <= pat_data_i;
            end
            bg_render_pkg::PAT_HI_GET: begin
                tile_o.pattern_hi <= pat_data_i;
            end
            default: ;                                     // Hold between fetches
        endcase
    end

endmodule

// ==== hdl/bg_addr_gen.sv ====
`timescale 1ns/1ps

module bg_addr_gen (
    input  logic                        clk_i,
    input  bg_render_pkg::fetch_step_e  step_next_i,
    input  logic                        render_en_i,
    input  bg_render_pkg::scroll_t      scroll_i,
    input  logic [7:0]                  tile_index_i,
    output bg_render_pkg::mem_port_t    nt_port_o,
    output bg_render_pkg::mem_port_t    pat_port_o
);

    bg_render_pkg::nt_addr_u tile_addr;                    // Tile index entry
    bg_render_pkg::nt_addr_u attr_addr;                    // Attribute byte for the 4x4 block
    bg_render_pkg::nt_addr_u nt_addr_r;

    logic [bg_render_pkg::VRAM_AW-1:0] pat_addr_r;
    logic                              plane;

    always_comb begin
        tile_addr.tile.base     = bg_render_pkg::NT_BASE;
        tile_addr.tile.nt_v     = scroll_i.nt_v;
        tile_addr.tile.nt_h     = scroll_i.nt_h;
        tile_addr.tile.coarse_y = scroll_i.coarse_y;
        tile_addr.tile.coarse_x = scroll_i.coarse_x;
    end

    always_comb begin
        attr_addr.attr.base        = bg_render_pkg::NT_BASE;
        attr_addr.attr.nt_v        = scroll_i.nt_v;
        attr_addr.attr.nt_h        = scroll_i.nt_h;
        attr_addr.attr.row         = bg_render_pkg::ATTR_ROW;
        attr_addr.attr.coarse_y_hi = scroll_i.coarse_y[4:2];
        attr_addr.attr.coarse_x_hi = scroll_i.coarse_x[4:2];
    end

    assign plane = (step_next_i == bg_render_pkg::PAT_HI_SET); // Upper bit plane

    always_ff @(posedge clk_i) begin
        if (step_next_i == bg_render_pkg::INDEX_SET) begin
            nt_addr_r <= tile_addr;
        end else if (step_next_i == bg_render_pkg::ATTR_SET) begin
            nt_addr_r <= attr_addr;
        end
        if ((step_next_i == bg_render_pkg::PAT_LO_SET) ||
            (step_next_i == bg_render_pkg::PAT_HI_SET)) begin
            pat_addr_r <= {1'b0, scroll_i.pattern_bank, tile_index_i, plane, scroll_i.fine_y};
        end
    end

    // Strobes come straight from the next step, data is due in the same cycle
    always_comb begin
        nt_port_o.addr  = nt_addr_r;
        nt_port_o.rd    = render_en_i && ((step_next_i == bg_render_pkg::INDEX_GET) ||
                                          (step_next_i == bg_render_pkg::ATTR_GET));
        pat_port_o.addr = pat_addr_r;
        pat_port_o.rd   = render_en_i && ((step_next_i == bg_render_pkg::PAT_LO_GET) ||
                                          (step_next_i == bg_render_pkg::PAT_HI_GET));
    end

endmodule

// ==== hdl/bg_fetch_sequencer.sv ====
`timescale 1ns/1ps

module bg_fetch_sequencer (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  bg_render_pkg::beam_t        beam_i,
    input  logic                        render_en_i,
    input  logic                        rendering_line_i,
    input  logic                        bg_en_i,
    input  logic [3:0]                  clip_start_i,
    output bg_render_pkg::fetch_step_e  step_next_o,
    output bg_render_pkg::shift_ctrl_t  shift_ctrl_o
);

    bg_render_pkg::fetch_step_e state_r;
    bg_render_pkg::fetch_step_e state_next;

    logic [bg_render_pkg::DOT_W-1:0] last_prefetch_dot;
    logic fetch_start;                                     // Tile fetch may begin here
    logic fetch_stop;                                      // Last tile of a window is in
    logic visible_line;
    logic visible_dot;
    logic render_dot;                                      // Dots where the shifters run

    assign last_prefetch_dot = bg_render_pkg::PREFETCH_END - 9'd1;

    assign fetch_start = rendering_line_i &&
                         ((beam_i.dot == '0) || (beam_i.dot == bg_render_pkg::PREFETCH_START));
    assign fetch_stop  = (beam_i.dot == bg_render_pkg::FETCH_STOP_DOT) ||
                         (beam_i.dot == last_prefetch_dot);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r <= bg_render_pkg::IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    always_comb begin
        state_next = state_r;
        case (state_r)
            bg_render_pkg::IDLE: begin
                if (fetch_start) begin
                    state_next = bg_render_pkg::INDEX_SET;
                end
            end
            bg_render_pkg::INDEX_SET:  state_next = bg_render_pkg::INDEX_GET;
            bg_render_pkg::INDEX_GET:  state_next = bg_render_pkg::ATTR_SET;
            bg_render_pkg::ATTR_SET:   state_next = bg_render_pkg::ATTR_GET;
            bg_render_pkg::ATTR_GET:   state_next = bg_render_pkg::PAT_LO_SET;
            bg_render_pkg::PAT_LO_SET: state_next = bg_render_pkg::PAT_LO_GET;
            bg_render_pkg::PAT_LO_GET: state_next = bg_render_pkg::PAT_HI_SET;
            bg_render_pkg::PAT_HI_SET: state_next = bg_render_pkg::PAT_HI_GET;
            bg_render_pkg::PAT_HI_GET: begin
                if (fetch_stop) begin                      // Window done, wait for next start
                    state_next = bg_render_pkg::IDLE;
                end else begin
                    state_next = bg_render_pkg::INDEX_SET;
                end
            end
            default:                   state_next = bg_render_pkg::IDLE;
        endcase
    end

    assign visible_line = beam_i.line < bg_render_pkg::VIS_LINES;
    assign visible_dot  = (beam_i.dot > {5'd0, clip_start_i}) &&
                          (beam_i.dot < bg_render_pkg::VIS_DOT_END);
    assign render_dot   = ((beam_i.dot > '0) && (beam_i.dot < bg_render_pkg::VIS_DOT_END)) ||
                          ((beam_i.dot > bg_render_pkg::PREFETCH_START) &&
                           (beam_i.dot < bg_render_pkg::PREFETCH_END));

    // Shifter control follows the beam directly
    always_comb begin
        shift_ctrl_o.shift   = render_en_i && rendering_line_i && render_dot;
        shift_ctrl_o.reload  = shift_ctrl_o.shift && (|beam_i.dot[8:3]) &&
                               (beam_i.dot[2:0] == 3'd0);  // Every 8th dot
        shift_ctrl_o.visible = visible_line && visible_dot && bg_en_i;
    end

    assign step_next_o = state_next;

endmodule

// ==== hdl/bg_render_pkg.sv ====
package bg_render_pkg;

    localparam int DOT_W   = 9;                            // Beam coordinate widths
    localparam int LINE_W  = 9;
    localparam int VRAM_AW = 14;                           // Video memory address width
    localparam int SHIFT_W = 16;

    localparam logic [LINE_W-1:0] VIS_LINES      = 9'd240;
    localparam logic [DOT_W-1:0]  VIS_DOT_END    = 9'd257; // First dot past the picture
    localparam logic [DOT_W-1:0]  PREFETCH_START = 9'd320; // Next line's first two tiles
    localparam logic [DOT_W-1:0]  PREFETCH_END   = 9'd337;
    localparam logic [DOT_W-1:0]  FETCH_STOP_DOT = 9'd256;
    localparam logic [1:0]        NT_BASE        = 2'b10;  // Nametables sit at 0x2000
    localparam logic [3:0]        ATTR_ROW       = 4'b1111;

    typedef struct packed {
        logic [DOT_W-1:0]  dot;
        logic [LINE_W-1:0] line;
    } beam_t;

    typedef struct packed {
        logic [2:0] fine_x;
        logic [2:0] fine_y;
        logic       nt_v;
        logic       nt_h;
        logic [4:0] coarse_y;
        logic [4:0] coarse_x;
        logic       pattern_bank;
    } scroll_t;

    // Two cycles per memory access, address first
    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        INDEX_SET  = 4'd1,
        INDEX_GET  = 4'd2,
        ATTR_SET   = 4'd3,
        ATTR_GET   = 4'd4,
        PAT_LO_SET = 4'd5,
        PAT_LO_GET = 4'd6,
        PAT_HI_SET = 4'd7,
        PAT_HI_GET = 4'd8
    } fetch_step_e;

    typedef struct packed {
        logic [1:0] base;
        logic       nt_v;
        logic       nt_h;
        logic [4:0] coarse_y;
        logic [4:0] coarse_x;
    } nt_tile_t;

    typedef struct packed {
        logic [1:0] base;
        logic       nt_v;
        logic       nt_h;
        logic [3:0] row;                                   // Attribute table tail of each nametable
        logic [2:0] coarse_y_hi;
        logic [2:0] coarse_x_hi;
    } nt_attr_t;

    typedef union packed {
        nt_tile_t tile;
        nt_attr_t attr;
    } nt_addr_u;

    typedef struct packed {
        logic [VRAM_AW-1:0] addr;
        logic               rd;
    } mem_port_t;

    typedef struct packed {
        logic shift;
        logic reload;
        logic visible;
    } shift_ctrl_t;

    typedef struct packed {
        logic [7:0] pattern_lo;
        logic [7:0] pattern_hi;
        logic [1:0] attr;
    } tile_data_t;

    typedef struct packed {
        logic [1:0] palette;
        logic [1:0] pattern;
    } pixel_t;

endpackage
